/* flist.f */
+incdir+verilog
verilog/ex_pkg.sv
verilog/operand_sel.sv
verilog/alu.sv
verilog/fu_alu.sv
verilog/fu_mult.sv
verilog/fu_branch.sv
verilog/cdb_arbiter.sv
verilog/ex_stage.sv
testbench/ex_stage_sva.sv
testbench/ex_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module ex_stage_tb -o sim_ex_stage

out=$(./obj_dir/sim_ex_stage)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi

/* testbench/ex_stage_tb.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage_tb;

  localparam int CLK_PERIOD = 20;
  localparam int MAX_TESTS  = 64;

  typedef struct {
    int                unit;
    ex_pkg::rs_entry_t ent;
    logic [`XLEN-1:0]  a;
    logic [`XLEN-1:0]  b;
    logic [`XLEN-1:0]  value;
    logic              taken;
    logic [`XLEN-1:0]  target;
  } test_t;

  logic                                  clock;
  logic                                  rst_n;
  ex_pkg::rs_entry_t [`NUM_FU-1:0]       issue;
  logic [`NUM_FU-1:0][`XLEN-1:0]         opa_value;
  logic [`NUM_FU-1:0][`XLEN-1:0]         opb_value;
  logic [`NUM_FU-1:0]                    ready;
  ex_pkg::cdb_t                          cdb;
  ex_pkg::br_out_t                       br_out;

  test_t            tests [MAX_TESTS];
  int               n_tests;
  logic [31:0]      lfsr;
  logic             table_built;
  // scoreboard, indexed by tag
  logic             cdb_pending [64];
  logic [`XLEN-1:0] cdb_expect  [64];
  logic             br_pending  [64];
  logic             br_taken    [64];
  logic [`XLEN-1:0] br_target   [64];
  int               outstanding;
  int               checks;
  int               errors;
  logic             watch_stall;
  logic             saw_stall;

  ex_stage dut0 (
    .clock     (clock),
    .rst_n     (rst_n),
    .issue     (issue),
    .opa_value (opa_value),
    .opb_value (opb_value),
    .ready     (ready),
    .cdb       (cdb),
    .br_out    (br_out)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  function automatic logic [63:0] rand_word();
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [63:0] ref_opa(input test_t t);
    case (t.ent.opa_sel)
      ex_pkg::OPA_IS_REGA:     return t.a;
      ex_pkg::OPA_IS_MEM_DISP: return 64'($signed(t.ent.inst[15:0]));
      ex_pkg::OPA_IS_NPC:      return t.ent.npc;
      default:                 return ~64'd3;
    endcase
  endfunction

  function automatic logic [63:0] ref_opb(input test_t t);
    case (t.ent.opb_sel)
      ex_pkg::OPB_IS_REGB:    return t.b;
      // literal sits in word bits 20:13
      ex_pkg::OPB_IS_ALU_IMM: return {56'd0, t.ent.inst[20:13]};
      default:                return 64'($signed(t.ent.inst[20:0])) << 2;
    endcase
  endfunction

  function automatic logic [63:0] ref_alu(input ex_pkg::alu_func_e f,
                                          input logic [63:0] x, input logic [63:0] y);
    case (f)
      ex_pkg::ALU_ADDQ:   return x + y;
      ex_pkg::ALU_SUBQ:   return x - y;
      ex_pkg::ALU_AND:    return x & y;
      ex_pkg::ALU_BIC:    return x & ~y;
      ex_pkg::ALU_BIS:    return x | y;
      ex_pkg::ALU_ORNOT:  return x | ~y;
      ex_pkg::ALU_XOR:    return x ^ y;
      ex_pkg::ALU_EQV:    return ~(x ^ y);
      ex_pkg::ALU_SRL:    return x >> y[5:0];
      ex_pkg::ALU_SLL:    return x << y[5:0];
      ex_pkg::ALU_SRA:    return 64'($signed(x) >>> y[5:0]);
      ex_pkg::ALU_MULQ:   return x * y;
      ex_pkg::ALU_CMPULT: return {63'd0, x < y};
      ex_pkg::ALU_CMPEQ:  return {63'd0, x == y};
      ex_pkg::ALU_CMPULE: return {63'd0, x <= y};
      ex_pkg::ALU_CMPLT:  return {63'd0, $signed(x) < $signed(y)};
      default:            return {63'd0, $signed(x) <= $signed(y)};
    endcase
  endfunction

  function automatic logic ref_taken(input test_t t);
    logic [2:0] cc;
    logic       c;
    cc = t.ent.inst[28:26];
    case (cc[1:0])
      2'd0:    c = !t.a[0];
      2'd1:    c = t.a == 0;
      2'd2:    c = $signed(t.a) < 0;
      default: c = $signed(t.a) <= 0;
    endcase
    return t.ent.uncond_branch || (t.ent.cond_branch && (c ^ cc[2]));
  endfunction

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic add_test(input int unit, input ex_pkg::alu_func_e f,
                          input ex_pkg::opa_sel_e asel, input ex_pkg::opb_sel_e bsel,
                          input logic [31:0] word, input logic [63:0] npc,
                          input logic [63:0] a, input logic [63:0] b,
                          input logic cond, input logic uncond);
    test_t t;
    t.unit                  = unit;
    t.ent.valid             = 1'b1;
    t.ent.tag               = n_tests[`TAG_W-1:0];
    t.ent.npc               = npc;
    t.ent.inst              = ex_pkg::inst_word_u'(word);
    t.ent.opa_sel           = asel;
    t.ent.opb_sel           = bsel;
    t.ent.alu_func          = f;
    t.ent.cond_branch       = cond;
    t.ent.uncond_branch     = uncond;
    t.a                     = a;
    t.b                     = b;
    // branch unit returns the link value
    t.value  = (unit == `FU_BR) ? npc : ref_alu(f, ref_opa(t), ref_opb(t));
    t.taken  = ref_taken(t);
    t.target = npc + ref_opb(t);
    tests[n_tests] = t;
    n_tests++;
  endtask

  ////////////////////////////////////////
  // issue and check
  ////////////////////////////////////////

  function automatic int next_for_unit(input int u, input int from, input int last);
    for (int i = from; i <= last; i++) begin
      if (tests[i].unit == u) return i;
    end
    return -1;
  endfunction

  task automatic drive_unit(input int u, input int idx);
    if (idx < 0) begin
      issue[u].valid <= 1'b0;
    end else begin
      issue[u]     <= tests[idx].ent;
      opa_value[u] <= tests[idx].a;
      opb_value[u] <= tests[idx].b;
    end
  endtask

  // all units fed in parallel, each waits on its own ready
  task automatic run_phase(input string name, input int first, input int last);
    int   cur [`NUM_FU];
    logic acc [`NUM_FU];
    logic busy;
    int   err0;
    err0 = errors;
    @(posedge clock);
    for (int u = 0; u < `NUM_FU; u++) begin
      cur[u] = next_for_unit(u, first, last);
      drive_unit(u, cur[u]);
    end
    busy = 1'b1;
    while (busy) begin
      @(negedge clock);
      for (int u = 0; u < `NUM_FU; u++) acc[u] = issue[u].valid && ready[u];
      @(posedge clock);
      busy = 1'b0;
      for (int u = 0; u < `NUM_FU; u++) begin
        if (acc[u]) begin
          cdb_pending[tests[cur[u]].ent.tag] = 1'b1;
          cdb_expect[tests[cur[u]].ent.tag]  = tests[cur[u]].value;
          outstanding++;
          if (u == `FU_BR) begin
            br_pending[tests[cur[u]].ent.tag] = 1'b1;
            br_taken[tests[cur[u]].ent.tag]   = tests[cur[u]].taken;
            br_target[tests[cur[u]].ent.tag]  = tests[cur[u]].target;
          end
          cur[u] = next_for_unit(u, cur[u] + 1, last);
          drive_unit(u, cur[u]);
        end
        if (cur[u] >= 0) busy = 1'b1;
      end
    end
    // drain every result
    while (outstanding != 0) @(posedge clock);
    repeat (2) @(posedge clock);
    if (errors == err0) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err0);
  endtask

  // scoreboard and grant order, sampled mid-cycle
  always @(negedge clock) begin
    if (rst_n) begin
      int top;
      top = -1;
      for (int i = 0; i < `NUM_FU; i++) if (dut0.req_cdb[i].valid) top = i;
      checks++;
      assert (top < 0 ? dut0.grant == '0 : dut0.grant == (`NUM_FU'(1) << top)) else begin
        $display("[ERROR] %0t: grant %b not highest requester", $time, dut0.grant);
        errors++;
      end
      if (watch_stall && ready != '1) saw_stall = 1'b1;
      if (cdb.valid) begin
        checks++;
        assert (cdb_pending[cdb.tag] && cdb.value == cdb_expect[cdb.tag]) else begin
          $display("[ERROR] %0t: cdb tag %0d value %h, expected %h pending %b", $time,
                   cdb.tag, cdb.value, cdb_expect[cdb.tag], cdb_pending[cdb.tag]);
          errors++;
        end
        if (cdb_pending[cdb.tag]) outstanding--;
        cdb_pending[cdb.tag] = 1'b0;
      end
      if (br_out.valid) begin
        checks++;
        assert (br_pending[br_out.tag] && br_out.taken == br_taken[br_out.tag]
                && br_out.target == br_target[br_out.tag]) else begin
          $display("[ERROR] %0t: branch tag %0d taken %b target %h, expected %b %h",
                   $time, br_out.tag, br_out.taken, br_out.target,
                   br_taken[br_out.tag], br_target[br_out.tag]);
          errors++;
        end
        br_pending[br_out.tag] = 1'b0;
      end
    end
  end

  // run length scales with the table
  initial begin
    wait (table_built);
    #(n_tests * (`MULT_STAGES + 10) * CLK_PERIOD);
    $display("timeout: the run did not finish in time");
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int p_alu;
    int p_opnd;
    int p_mult;
    int p_br;
    int p_cont;
    logic [63:0] vals [4];
    clock       = 1'b0;
    rst_n       = 1'b0;
    issue       = '0;
    opa_value   = '0;
    opb_value   = '0;
    lfsr        = 32'h5cb8_0c1c;
    n_tests     = 0;
    table_built = 1'b0;
    outstanding = 0;
    checks      = 0;
    errors      = 0;
    watch_stall = 1'b0;
    saw_stall   = 1'b0;
    for (int i = 0; i < 64; i++) begin
      cdb_pending[i] = 1'b0;
      br_pending[i]  = 1'b0;
    end

    // every alu function, alternating alu0 and alu1
    p_alu = n_tests;
    for (int f = 0; f <= 16; f++) begin
      if (f != 11) add_test(f % 2, ex_pkg::alu_func_e'(f), ex_pkg::OPA_IS_REGA,
                            ex_pkg::OPB_IS_REGB, '0, '0, rand_word(), rand_word(), 0, 0);
    end
    // sign boundaries
    add_test(0, ex_pkg::ALU_CMPLT, ex_pkg::OPA_IS_REGA, ex_pkg::OPB_IS_REGB, '0, '0,
             64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 0, 0);
    add_test(1, ex_pkg::ALU_CMPULT, ex_pkg::OPA_IS_REGA, ex_pkg::OPB_IS_REGB, '0, '0,
             64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 0, 0);
    add_test(0, ex_pkg::ALU_CMPLE, ex_pkg::OPA_IS_REGA, ex_pkg::OPB_IS_REGB, '0, '0,
             64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff, 0, 0);
    add_test(1, ex_pkg::ALU_CMPULE, ex_pkg::OPA_IS_REGA, ex_pkg::OPB_IS_REGB, '0, '0,
             64'hffff_ffff_ffff_ffff, 64'd0, 0, 0);
    add_test(0, ex_pkg::ALU_SRA, ex_pkg::OPA_IS_REGA, ex_pkg::OPB_IS_REGB, '0, '0,
             64'hf000_0000_0000_0010, 64'd4, 0, 0);

    // immediate and operand sources
    p_opnd = n_tests;
    add_test(`FU_LS, ex_pkg::ALU_ADDQ, ex_pkg::OPA_IS_MEM_DISP, ex_pkg::OPB_IS_REGB,
             32'h2000_fff0, '0, '0, rand_word(), 0, 0);
    add_test(0, ex_pkg::ALU_BIS, ex_pkg::OPA_IS_REGA, ex_pkg::OPB_IS_ALU_IMM,
             32'h4018_7000, '0, rand_word(), '0, 0, 0);
    add_test(1, ex_pkg::ALU_ADDQ, ex_pkg::OPA_IS_NPC, ex_pkg::OPB_IS_REGB,
             '0, 64'h0000_0001_2000_0104, '0, 64'd8, 0, 0);
    add_test(`FU_LS, ex_pkg::ALU_AND, ex_pkg::OPA_IS_NOT3, ex_pkg::OPB_IS_REGB,
             '0, '0, '0, rand_word(), 0, 0);

    // back to back products
    p_mult = n_tests;
    for (int i = 0; i < 6; i++) begin
      add_test(`FU_MULT, ex_pkg::ALU_MULQ, ex_pkg::OPA_IS_REGA, ex_pkg::OPB_IS_REGB,
               '0, '0, rand_word(), rand_word(), 0, 0);
    end

    // eight condition codes, then two unconditional
    p_br = n_tests;
    vals[0] = 64'd0;
    vals[1] = 64'd1;
    vals[2] = 64'd2;
    vals[3] = 64'hffff_ffff_ffff_fffe;
    for (int cc = 0; cc < 10; cc++) begin
      add_test(`FU_BR, ex_pkg::ALU_ADDQ, ex_pkg::OPA_IS_NPC, ex_pkg::OPB_IS_BR_DISP,
               {3'b111, 3'(cc), 5'd0, 21'(rand_word())},
               64'h0000_0000_0040_0000 + 64'(cc * 4),
               vals[(cc + (cc >> 2)) % 4], '0, cc < 8, cc >= 8);
    end

    // all five units every cycle
    p_cont = n_tests;
    for (int r = 0; r < 3; r++) begin
      for (int u = 0; u < `NUM_FU; u++) begin
        add_test(u, (u == `FU_MULT) ? ex_pkg::ALU_MULQ : ex_pkg::ALU_ADDQ,
                 (u == `FU_BR) ? ex_pkg::OPA_IS_NPC : ex_pkg::OPA_IS_REGA,
                 (u == `FU_BR) ? ex_pkg::OPB_IS_BR_DISP : ex_pkg::OPB_IS_REGB,
                 32'h0000_0010, 64'h1000 + 64'(r * 4), rand_word(), rand_word(),
                 0, u == `FU_BR);
      end
    end
    table_built = 1'b1;

    repeat (5) @(posedge clock);
    rst_n <= 1'b1;
    @(negedge clock);
    checks++;
    assert (ready == '1 && !cdb.valid && !br_out.valid) else begin
      $display("[ERROR] %0t: after reset ready %b cdb %b br %b", $time, ready,
               cdb.valid, br_out.valid);
      errors++;
    end
    $display("test reset: %s", (errors == 0) ? "ok" : "error");

    run_phase("alu_functions", p_alu, p_opnd - 1);
    run_phase("operand_sources", p_opnd, p_mult - 1);
    run_phase("multiplier", p_mult, p_br - 1);
    run_phase("branches", p_br, p_cont - 1);
    watch_stall = 1'b1;
    run_phase("contention", p_cont, n_tests - 1);
    checks++;
    assert (saw_stall) else begin
      $display("[ERROR] %0t: ready never dropped under contention", $time);
      errors++;
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* testbench/ex_stage_sva.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage_sva (
  input logic                            clock,
  input logic                            rst_n,
  input ex_pkg::rs_entry_t [`NUM_FU-1:0] issue,
  input logic [`NUM_FU-1:0]              ready,
  input logic [`NUM_FU-1:0]              grant,
  input ex_pkg::cdb_t [`NUM_FU-1:0]      req_cdb,
  input ex_pkg::cdb_t                    cdb,
  input ex_pkg::br_out_t                 br_out
);

  logic [`TAG_W-1:0]  granted_tag;
  logic [`NUM_FU-1:0] req_valid;
  logic               br_accept;

  // request levels and the tag of whichever unit holds the grant
  always_comb begin
    granted_tag = '0;
    for (int i = 0; i < `NUM_FU; i++) begin
      req_valid[i] = req_cdb[i].valid;
      if (grant[i]) granted_tag = req_cdb[i].tag;
    end
  end

  assign br_accept = issue[`FU_BR].valid && ready[`FU_BR];

  ////////////////////////////////////////
  // cdb and branch port
  ////////////////////////////////////////

  cdb_quiet_in_reset: assert property (@(posedge clock) !rst_n |-> !cdb.valid)
    else $error("cdb valid while in reset");

  // at most one grant and only to a requester
  one_grant_to_requester: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0(grant) && ((grant & ~req_valid) == '0) && ((|grant) == (|req_valid)))
    else $error("cdb grant not a single requesting unit");

  grant_reaches_cdb: assert property (@(posedge clock) disable iff (!rst_n)
    (|grant) |=> (cdb.valid && cdb.tag == $past(granted_tag)))
    else $error("granted request missing from cdb");

  // one pulse per accepted branch, nothing otherwise
  br_pulse_per_issue: assert property (@(posedge clock) disable iff (!rst_n)
    1'b1 |=> (br_out.valid == $past(br_accept)))
    else $error("branch port valid does not follow branch issue");

endmodule

bind ex_stage ex_stage_sva sva0 (
  .clock   (clock),
  .rst_n   (rst_n),
  .issue   (issue),
  .ready   (ready),
  .grant   (grant),
  .req_cdb (req_cdb),
  .cdb     (cdb),
  .br_out  (br_out)
);

/* verilog/ex_stage.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module ex_stage (
  input  logic                                  clock,
  input  logic                                  rst_n,
  input  ex_pkg::rs_entry_t [`NUM_FU-1:0]       issue,
  input  logic [`NUM_FU-1:0][`XLEN-1:0]         opa_value,
  input  logic [`NUM_FU-1:0][`XLEN-1:0]         opb_value,
  output logic [`NUM_FU-1:0]                    ready,
  output ex_pkg::cdb_t                          cdb,
  output ex_pkg::br_out_t                       br_out
);

  // per-unit result requests and grants
  ex_pkg::cdb_t [`NUM_FU-1:0] req_cdb;
  logic         [`NUM_FU-1:0] grant;

  ////////////////////////////////////////
  // functional units
  ////////////////////////////////////////

  fu_alu u_alu0 (
    .clock (clock), .rst_n (rst_n), .entry (issue[`FU_ALU0]),
    .opa_value (opa_value[`FU_ALU0]), .opb_value (opb_value[`FU_ALU0]),
    .grant (grant[`FU_ALU0]), .ready (ready[`FU_ALU0]), .req_cdb (req_cdb[`FU_ALU0])
  );

  fu_alu u_alu1 (
    .clock (clock), .rst_n (rst_n), .entry (issue[`FU_ALU1]),
    .opa_value (opa_value[`FU_ALU1]), .opb_value (opb_value[`FU_ALU1]),
    .grant (grant[`FU_ALU1]), .ready (ready[`FU_ALU1]), .req_cdb (req_cdb[`FU_ALU1])
  );

  // load/store address add
  fu_alu u_ls (
    .clock (clock), .rst_n (rst_n), .entry (issue[`FU_LS]),
    .opa_value (opa_value[`FU_LS]), .opb_value (opb_value[`FU_LS]),
    .grant (grant[`FU_LS]), .ready (ready[`FU_LS]), .req_cdb (req_cdb[`FU_LS])
  );

  fu_mult u_mult (
    .clock (clock), .rst_n (rst_n), .entry (issue[`FU_MULT]),
    .opa_value (opa_value[`FU_MULT]), .opb_value (opb_value[`FU_MULT]),
    .grant (grant[`FU_MULT]), .ready (ready[`FU_MULT]), .req_cdb (req_cdb[`FU_MULT])
  );

  fu_branch u_br (
    .clock (clock), .rst_n (rst_n), .entry (issue[`FU_BR]),
    .opa_value (opa_value[`FU_BR]), .opb_value (opb_value[`FU_BR]),
    .grant (grant[`FU_BR]), .ready (ready[`FU_BR]), .req_cdb (req_cdb[`FU_BR]),
    .br_out (br_out)
  );

  // single shared result bus
  cdb_arbiter u_arb (
    .clock (clock),
    .rst_n (rst_n),
    .req   (req_cdb),
    .grant (grant),
    .cdb   (cdb)
  );

endmodule

/* verilog/cdb_arbiter.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module cdb_arbiter (
  input  logic                         clock,
  input  logic                         rst_n,
  input  ex_pkg::cdb_t [`NUM_FU-1:0]   req,
  output logic         [`NUM_FU-1:0] grant,
  output ex_pkg::cdb_t                 cdb
);

  localparam int SEL_W = $clog2(`NUM_FU);

  logic [SEL_W-1:0]  sel;
  logic              any_req;
  logic              cdb_valid;
  logic [`TAG_W-1:0] cdb_tag;
  logic [`XLEN-1:0]  cdb_value;

  ////////////////////////////////////////
  // fixed priority, highest index wins
  ////////////////////////////////////////

  always_comb begin
    sel     = '0;
    any_req = 1'b0;
    // later hits override earlier ones
    for (int i = 0; i < `NUM_FU; i++) begin
      if (req[i].valid) begin
        sel     = SEL_W'(i);
        any_req = 1'b1;
      end
    end
    grant      = '0;
    grant[sel] = any_req;
  end

  // broadcast one edge after the grant
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= any_req;
    end
  end

  always_ff @(posedge clock) begin
    if (any_req) begin
      cdb_tag   <= req[sel].tag;
      cdb_value <= req[sel].value;
    end
  end

  assign cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

endmodule

/* verilog/fu_branch.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module fu_branch (
  input  logic              clock,
  input  logic              rst_n,
  input  ex_pkg::rs_entry_t entry,
  input  logic [`XLEN-1:0]  opa_value,
  input  logic [`XLEN-1:0]  opb_value,
  input  logic              grant,
  output logic              ready,
  output ex_pkg::cdb_t      req_cdb,
  output ex_pkg::br_out_t   br_out
);

  logic [`XLEN-1:0]  opa;
  logic [`XLEN-1:0]  opb;
  logic [2:0]        cond_code;
  logic              base_cond;
  logic              taken;
  logic              accept;
  logic              hold_valid;
  logic [`TAG_W-1:0] hold_tag;
  logic [`XLEN-1:0]  hold_link;
  logic              br_valid;
  logic [`TAG_W-1:0] br_tag;
  logic              br_taken;
  logic [`XLEN-1:0]  br_target;

  // entry selects npc and br_disp for the target add
  operand_sel u_operand_sel (
    .entry     (entry),
    .opa_value (opa_value),
    .opb_value (opb_value),
    .opa       (opa),
    .opb       (opb)
  );

  ////////////////////////////////////////
  // condition on the raw rega value
  ////////////////////////////////////////

  assign cond_code = entry.inst.br.opcode[2:0];

  always_comb begin
    case (cond_code[1:0])
      2'b00:   base_cond = !opa_value[0];
      2'b01:   base_cond = opa_value == '0;
      2'b10:   base_cond = opa_value[`XLEN-1];
      default: base_cond = opa_value[`XLEN-1] || (opa_value == '0);
    endcase
  end

  // bit 2 flips the sense
  assign taken  = entry.uncond_branch || (entry.cond_branch && (base_cond ^ cond_code[2]));
  assign ready  = !hold_valid || grant;
  assign accept = entry.valid && ready;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
      br_valid   <= 1'b0;
    end else begin
      // branch port pulses once per issue
      br_valid <= accept;
      if (accept) begin
        hold_valid <= 1'b1;
      end else if (grant) begin
        hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      hold_tag  <= entry.tag;
      // link value goes out over the cdb
      hold_link <= entry.npc;
      br_tag    <= entry.tag;
      br_taken  <= taken;
      br_target <= opa + opb;
    end
  end

  assign req_cdb = '{valid: hold_valid, tag: hold_tag, value: hold_link};
  assign br_out  = '{valid: br_valid, tag: br_tag, taken: br_taken, target: br_target};

endmodule

/* verilog/fu_mult.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module fu_mult (
  input  logic              clock,
  input  logic              rst_n,
  input  ex_pkg::rs_entry_t entry,
  input  logic [`XLEN-1:0]  opa_value,
  input  logic [`XLEN-1:0]  opb_value,
  input  logic              grant,
  output logic              ready,
  output ex_pkg::cdb_t      req_cdb
);

  // multiplier bits consumed per stage
  localparam int CW   = `XLEN / `MULT_STAGES;
  localparam int LAST = `MULT_STAGES - 1;

  logic [`XLEN-1:0]       opa;
  logic [`XLEN-1:0]       opb;
  logic [`XLEN-1:0]       first_pp;
  logic                   advance;
  logic [`MULT_STAGES-1:0] st_valid;
  logic [`TAG_W-1:0]      st_tag    [`MULT_STAGES];
  logic [`XLEN-1:0]       st_prod   [`MULT_STAGES];
  // remaining operands, not needed past the second to last stage
  logic [`XLEN-1:0]       st_mcand  [`MULT_STAGES-1];
  logic [`XLEN-1:0]       st_mplier [`MULT_STAGES-1];

  operand_sel u_operand_sel (
    .entry     (entry),
    .opa_value (opa_value),
    .opb_value (opb_value),
    .opa       (opa),
    .opb       (opb)
  );

  // whole pipe stalls on an ungranted result in the last stage
  assign advance = !st_valid[LAST] || grant;
  assign ready   = advance;

  // low chunk of the multiplier
  assign first_pp = opa * {{(`XLEN-CW){1'b0}}, opb[CW-1:0]};

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      st_valid <= '0;
    end else if (advance) begin
      st_valid <= {st_valid[LAST-1:0], entry.valid};
    end
  end

  // partial sums, tags ride along
  always_ff @(posedge clock) begin
    if (advance) begin
      st_tag[0]    <= entry.tag;
      st_prod[0]   <= first_pp;
      st_mcand[0]  <= opa << CW;
      st_mplier[0] <= opb >> CW;
      for (int s = 1; s < `MULT_STAGES; s++) begin
        st_tag[s]  <= st_tag[s-1];
        st_prod[s] <= st_prod[s-1]
                      + st_mcand[s-1] * {{(`XLEN-CW){1'b0}}, st_mplier[s-1][CW-1:0]};
      end
      for (int s = 1; s < LAST; s++) begin
        st_mcand[s]  <= st_mcand[s-1] << CW;
        st_mplier[s] <= st_mplier[s-1] >> CW;
      end
    end
  end

  // last stage doubles as the holding register
  assign req_cdb = '{valid: st_valid[LAST], tag: st_tag[LAST], value: st_prod[LAST]};

endmodule

/* verilog/fu_alu.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module fu_alu (
  input  logic              clock,
  input  logic              rst_n,
  input  ex_pkg::rs_entry_t entry,
  input  logic [`XLEN-1:0]  opa_value,
  input  logic [`XLEN-1:0]  opb_value,
  input  logic              grant,
  output logic              ready,
  output ex_pkg::cdb_t      req_cdb
);

  logic [`XLEN-1:0]  opa;
  logic [`XLEN-1:0]  opb;
  logic [`XLEN-1:0]  result;
  logic              accept;
  logic              hold_valid;
  logic [`TAG_W-1:0] hold_tag;
  logic [`XLEN-1:0]  hold_value;

  operand_sel u_operand_sel (
    .entry     (entry),
    .opa_value (opa_value),
    .opb_value (opb_value),
    .opa       (opa),
    .opb       (opb)
  );

  alu u_alu (
    .opa    (opa),
    .opb    (opb),
    .func   (entry.alu_func),
    .result (result)
  );

  // free slot, or the held result leaves this edge
  assign ready  = !hold_valid || grant;
  assign accept = entry.valid && ready;

  // holding register
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
    end else if (accept) begin
      hold_valid <= 1'b1;
    end else if (grant) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      hold_tag   <= entry.tag;
      hold_value <= result;
    end
  end

  assign req_cdb = '{valid: hold_valid, tag: hold_tag, value: hold_value};

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu (
  input  logic [`XLEN-1:0] opa,
  input  logic [`XLEN-1:0] opb,
  input  ex_pkg::alu_func_e func,
  output logic [`XLEN-1:0] result
);

  logic [5:0]       shamt;
  logic [`XLEN-1:0] srl_val;
  logic [`XLEN-1:0] sign_fill;
  logic             lt_signed;
  logic             lt_unsigned;
  logic             eq;

  ////////////////////////////////////////
  // shifts
  ////////////////////////////////////////

  // only low 6 bits of opb count
  assign shamt   = opb[5:0];
  assign srl_val = opa >> shamt;

  // vacated high bits, set only for a negative opa
  assign sign_fill = ~({`XLEN{1'b1}} >> shamt) & {`XLEN{opa[`XLEN-1]}};

  ////////////////////////////////////////
  // compares
  ////////////////////////////////////////

  assign lt_unsigned = opa < opb;
  assign eq          = opa == opb;

  // same sign behaves like unsigned
  // otherwise the negative one is smaller
  assign lt_signed = (opa[`XLEN-1] == opb[`XLEN-1]) ? lt_unsigned : opa[`XLEN-1];

  always_comb begin
    case (func)
      ex_pkg::ALU_ADDQ:   result = opa + opb;
      ex_pkg::ALU_SUBQ:   result = opa - opb;
      ex_pkg::ALU_AND:    result = opa & opb;
      ex_pkg::ALU_BIC:    result = opa & ~opb;
      ex_pkg::ALU_BIS:    result = opa | opb;
      ex_pkg::ALU_ORNOT:  result = opa | ~opb;
      ex_pkg::ALU_XOR:    result = opa ^ opb;
      ex_pkg::ALU_EQV:    result = opa ^ ~opb;
      ex_pkg::ALU_SRL:    result = srl_val;
      ex_pkg::ALU_SLL:    result = opa << shamt;
      ex_pkg::ALU_SRA:    result = srl_val | sign_fill;
      // compare results land in bit 0
      ex_pkg::ALU_CMPULT: result = {{(`XLEN-1){1'b0}}, lt_unsigned};
      ex_pkg::ALU_CMPEQ:  result = {{(`XLEN-1){1'b0}}, eq};
      ex_pkg::ALU_CMPULE: result = {{(`XLEN-1){1'b0}}, lt_unsigned | eq};
      ex_pkg::ALU_CMPLT:  result = {{(`XLEN-1){1'b0}}, lt_signed};
      ex_pkg::ALU_CMPLE:  result = {{(`XLEN-1){1'b0}}, lt_signed | eq};
      // mulq lives in the multiplier unit
      default:            result = `ALU_POISON;
    endcase
  end

endmodule

/* verilog/operand_sel.sv */
`timescale 1ns/1ps
`include "ex_defines.svh"

module operand_sel (
  input  ex_pkg::rs_entry_t  entry,
  input  logic [`XLEN-1:0]   opa_value,
  input  logic [`XLEN-1:0]   opb_value,
  output logic [`XLEN-1:0]   opa,
  output logic [`XLEN-1:0]   opb
);

  logic [`XLEN-1:0] mem_disp;
  logic [`XLEN-1:0] br_disp;
  logic [`XLEN-1:0] alu_imm;

  ////////////////////////////////////////
  // immediates
  ////////////////////////////////////////

  // 16-bit memory displacement, sign extended
  assign mem_disp = {{(`XLEN-16){entry.inst.mem.disp[15]}}, entry.inst.mem.disp};

  // branch displacement in words, so times 4
  assign br_disp = {{(`XLEN-23){entry.inst.br.disp[20]}}, entry.inst.br.disp, 2'b00};

  // 8-bit operate literal, zero extended
  assign alu_imm = {{(`XLEN-8){1'b0}}, entry.inst.op.lit};

  ////////////////////////////////////////
  // operand muxes
  ////////////////////////////////////////

  // opa, all four codes legal
  always_comb begin
    case (entry.opa_sel)
      ex_pkg::OPA_IS_REGA:     opa = opa_value;
      ex_pkg::OPA_IS_MEM_DISP: opa = mem_disp;
      ex_pkg::OPA_IS_NPC:      opa = entry.npc;
      default:                 opa = ~`XLEN'(3);
    endcase
  end

  // opb, unused code shows up as poison
  always_comb begin
    case (entry.opb_sel)
      ex_pkg::OPB_IS_REGB:    opb = opb_value;
      ex_pkg::OPB_IS_ALU_IMM: opb = alu_imm;
      ex_pkg::OPB_IS_BR_DISP: opb = br_disp;
      default:                opb = `OPB_POISON;
    endcase
  end

endmodule

/* verilog/ex_pkg.sv */
`include "ex_defines.svh"

package ex_pkg;

  ////////////////////////////////////////
  // decode fields carried by the entry
  ////////////////////////////////////////

  // alu function codes, mulq only used by the multiplier
  typedef enum logic [4:0] {
    ALU_ADDQ, ALU_SUBQ, ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT,
    ALU_XOR, ALU_EQV, ALU_SRL, ALU_SLL, ALU_SRA, ALU_MULQ,
    ALU_CMPULT, ALU_CMPEQ, ALU_CMPULE, ALU_CMPLT, ALU_CMPLE
  } alu_func_e;

  // operand a source
  typedef enum logic [1:0] {
    OPA_IS_REGA, OPA_IS_MEM_DISP, OPA_IS_NPC, OPA_IS_NOT3
  } opa_sel_e;

  // operand b source, code 3 is illegal
  typedef enum logic [1:0] {
    OPB_IS_REGB, OPB_IS_ALU_IMM, OPB_IS_BR_DISP
  } opb_sel_e;

  ////////////////////////////////////////
  // instruction word views
  ////////////////////////////////////////

  // memory format
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [15:0] disp;
  } mem_fmt_t;

  // branch format, opcode[2:0] is the condition code
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [20:0] disp;
  } br_fmt_t;

  // operate format with literal
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] ra;
    logic [7:0] lit;
    logic       lit_flag;
    logic [6:0] func;
    logic [4:0] rc;
  } op_fmt_t;

  typedef union packed {
    mem_fmt_t mem;
    br_fmt_t  br;
    op_fmt_t  op;
  } inst_word_u;

  ////////////////////////////////////////
  // entries and result buses
  ////////////////////////////////////////

  typedef struct packed {
    logic             valid;
    logic [`TAG_W-1:0] tag;
    logic [`XLEN-1:0] npc;
    inst_word_u       inst;
    opa_sel_e         opa_sel;
    opb_sel_e         opb_sel;
    alu_func_e        alu_func;
    logic             cond_branch;
    logic             uncond_branch;
  } rs_entry_t;

  typedef struct packed {
    logic              valid;
    logic [`TAG_W-1:0] tag;
    logic [`XLEN-1:0]  value;
  } cdb_t;

  typedef struct packed {
    logic              valid;
    logic [`TAG_W-1:0] tag;
    logic              taken;
    logic [`XLEN-1:0]  target;
  } br_out_t;

endpackage

/* verilog/ex_defines.svh */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

// machine word
`define XLEN        64
// physical register tag
`define TAG_W       6

////////////////////////////////////////
// functional units
////////////////////////////////////////

`define NUM_FU      5
// multiplier pipe depth, holding reg is the last stage
`define MULT_STAGES 4

// unit index, higher index wins the cdb
`define FU_ALU0     0
`define FU_ALU1     1
`define FU_LS       2
`define FU_MULT     3
`define FU_BR       4

// marker words for an illegal opb select or alu function
`define OPB_POISON  64'hbaad_beef_dead_beef
`define ALU_POISON  64'hdead_beef_baad_beef

`endif
